// ==== sources.f ====
verilog/organ_pkg.sv
verilog/key_conditioner.sv
verilog/speed_register.sv
verilog/tone_generator.sv
verilog/display_refresh.sv
verilog/seven_seg_decoder.sv
verilog/organ_top.sv
tb/organ_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the organ testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/100ps \
  -f sources.f --top-module organ_tb -Mdir "$BUILD_DIR"

# The log decides the result, not the exit status of the run
"./$BUILD_DIR/Vorgan_tb" 2>&1 | tee "$LOG_FILE"

if grep -q "Finished with errors" "$LOG_FILE"; then
  echo "Simulation FAILED"
  exit 1
fi

if ! grep -q "Finished with no errors" "$LOG_FILE"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation PASSED"

// ==== tb/organ_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module organ_tb;

  // ==================================================
  // Test constants
  // ==================================================

  localparam int TONE_HALF_CYCLES = 10;
  localparam int REPEAT_CYCLES    = 20;
  localparam int REFRESH_CYCLES   = 50;
  // DUT keeps its defaults for these two
  localparam int DEFAULT_COUNT    = 12499;
  localparam int SPEED_STEP       = 100;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RANDOM_SEED  = 52391;
  localparam int HEX_W        = 7 * organ_pkg::NUM_DIGITS;

  // Rough length of all tests in cycles, limit leaves wide margin
  localparam int TEST_CYCLES = RESET_CYCLES + 6 * (REFRESH_CYCLES + 4)
                             + 8 * REPEAT_CYCLES + 12 * TONE_HALF_CYCLES;
  localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  localparam logic [2:0] KEYS_IDLE  = 3'b111;
  localparam logic [2:0] UP_MASK    = 3'b001 << organ_pkg::key_up;
  localparam logic [2:0] DOWN_MASK  = 3'b001 << organ_pkg::key_down;
  localparam logic [2:0] CLEAR_MASK = 3'b001 << organ_pkg::key_clear;

  // Active-low glyphs for 0..F, segment a in bit 0
  localparam logic [6:0] GLYPH_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                                             CLK_50M;
  logic                                             reset;
  logic [organ_pkg::key_clear:0]                    keys;
  logic                                             mute;
  organ_pkg::audio_sample_t                         audio_sample;
  organ_pkg::segments_t [organ_pkg::NUM_DIGITS-1:0] hex;

  int cycle_count = 0;
  int current_offset;

  organ_top #(
    .TONE_HALF_CYCLES (TONE_HALF_CYCLES),
    .REPEAT_CYCLES    (REPEAT_CYCLES),
    .REFRESH_CYCLES   (REFRESH_CYCLES)
  ) u_dut (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .keys         (keys),
    .mute         (mute),
    .audio_sample (audio_sample),
    .hex          (hex)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  // Watchdog on the whole run
  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: tests did not complete within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  // ==================================================
  // Helpers
  // ==================================================

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  // Held length counts from the synchronized level, tail waits out the sync flops
  task automatic press_keys(input logic [2:0] mask, input int n);
    keys = ~mask;
    wait_cycles(n);
    keys = KEYS_IDLE;
    wait_cycles(2);
  endtask

  // Sampling count for a given offset, 16-bit wrap
  function automatic int count_for(input int offset);
    return (DEFAULT_COUNT + offset) & 32'h0000_FFFF;
  endfunction

  function automatic logic [HEX_W-1:0] display_pattern(input int count);
    logic [23:0]      value;
    logic [HEX_W-1:0] pattern;
    value = {8'h00, count[15:0]};
    for (int i = 0; i < organ_pkg::NUM_DIGITS; i++)
      pattern[7*i +: 7] = GLYPH_TABLE[value[4*i +: 4]];
    return pattern;
  endfunction

  task automatic check_display(input int count, input string what);
    check_value(64'(hex), 64'(display_pattern(count)), what);
  endtask

  function automatic logic is_full_scale(input logic [7:0] level);
    return (level == 8'h7F) || (level == 8'h80);
  endfunction

  // Measures several half periods, aligned on the next square edge
  task automatic measure_tone(input int half_periods);
    logic [7:0] prev;
    logic [7:0] level;
    logic [7:0] next_level;
    int         length;
    prev = audio_sample;
    while (audio_sample == prev)
      @(negedge CLK_50M);
    level = audio_sample;
    check_value(64'(is_full_scale(level)), 64'd1, "tone level is full scale");
    for (int n = 0; n < half_periods; n++)
    begin
      length = 0;
      while (audio_sample == level)
      begin
        @(negedge CLK_50M);
        length++;
      end
      next_level = (level == 8'h7F) ? 8'h80 : 8'h7F;
      check_value(64'(length), 64'(TONE_HALF_CYCLES), "tone half period length");
      check_value({56'd0, audio_sample}, {56'd0, next_level}, "tone level after edge");
      level = audio_sample;
    end
  endtask

  // ==================================================
  // Directed tests
  // ==================================================

  task automatic test_reset_display();
    // Square starts low, so the first half period is negative full scale
    check_value({56'd0, audio_sample}, 64'h80, "sample low after reset");
    check_display(0, "all digits zero after reset");
    wait_cycles(REFRESH_CYCLES + 2);
    check_display(count_for(0), "first refresh shows default count");
  endtask

  task automatic test_tone();
    measure_tone(4);
  endtask

  task automatic test_mute();
    mute = 1'b1;
    wait_cycles(2);
    for (int n = 0; n < 2 * TONE_HALF_CYCLES; n++)
    begin
      check_value({56'd0, audio_sample}, 64'd0, "sample while muted");
      @(negedge CLK_50M);
    end
    mute = 1'b0;
    wait_cycles(2);
    check_value(64'(is_full_scale(audio_sample)), 64'd1, "sample after mute release");
    measure_tone(2);
  endtask

  task automatic test_step_up();
    press_keys(UP_MASK, REPEAT_CYCLES);
    current_offset = current_offset + SPEED_STEP;
    wait_cycles(REFRESH_CYCLES + 4);
    check_display(count_for(current_offset), "display after one step up");
  endtask

  task automatic test_step_down_double();
    press_keys(DOWN_MASK, 2 * REPEAT_CYCLES);
    current_offset = current_offset - 2 * SPEED_STEP;
    wait_cycles(REFRESH_CYCLES + 4);
    check_display(count_for(current_offset), "display after two steps down");
    // Both keys pulse together and cancel
    press_keys(UP_MASK | DOWN_MASK, 3 * REPEAT_CYCLES);
    wait_cycles(REFRESH_CYCLES + 4);
    check_display(count_for(current_offset), "display after double press");
  endtask

  task automatic test_clear();
    int hold_len;
    // Leave a nonzero offset for the clear key to remove
    press_keys(UP_MASK, 2 * REPEAT_CYCLES);
    current_offset = current_offset + 2 * SPEED_STEP;
    wait_cycles(REFRESH_CYCLES + 4);
    check_display(count_for(current_offset), "display before clear");
    hold_len = 3 + int'($urandom % 8);
    press_keys(CLEAR_MASK, hold_len);
    current_offset = 0;
    wait_cycles(REFRESH_CYCLES + 4);
    check_display(count_for(current_offset), "display after clear");
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial
  begin
    void'($urandom(RANDOM_SEED));
    reset = 1'b1;
    keys = KEYS_IDLE;
    mute = 1'b0;
    current_offset = 0;
    wait_cycles(RESET_CYCLES);
    reset = 1'b0;

    test_reset_display();
    test_tone();
    test_mute();
    test_step_up();
    test_step_down_double();
    test_clear();

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/organ_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module organ_top #(
  parameter int unsigned TONE_HALF_CYCLES = 25000,
  parameter int unsigned REPEAT_CYCLES    = 5000000,
  parameter int unsigned REFRESH_CYCLES   = 25000000,
  parameter int          DEFAULT_COUNT    = 12499,
  parameter int          SPEED_STEP       = 100
) (
  input  wire logic                                         CLK_50M,
  input  wire logic                                         reset,
  input  wire logic [organ_pkg::key_clear:0]                keys,
  input  wire logic                                         mute,
  output wire organ_pkg::audio_sample_t                     audio_sample,
  output wire organ_pkg::segments_t [organ_pkg::NUM_DIGITS-1:0] hex
);

  wire logic                       step_up;
  wire logic                       step_down;
  wire logic                       clear_level;
  wire organ_pkg::sample_count_t   sample_count;
  wire organ_pkg::display_digits_t digits;

  // ==================================================
  // Speed control path
  // ==================================================

  key_conditioner #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) u_key_conditioner (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .keys        (keys),
    .step_up     (step_up),
    .step_down   (step_down),
    .clear_level (clear_level)
  );

  speed_register #(
    .DEFAULT_COUNT (DEFAULT_COUNT),
    .SPEED_STEP    (SPEED_STEP)
  ) u_speed_register (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .step_up      (step_up),
    .step_down    (step_down),
    .clear_level  (clear_level),
    .sample_count (sample_count)
  );

  // ==================================================
  // Audio
  // ==================================================

  tone_generator #(
    .TONE_HALF_CYCLES (TONE_HALF_CYCLES)
  ) u_tone_generator (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .mute         (mute),
    .audio_sample (audio_sample)
  );

  // ==================================================
  // Seven-segment display
  // ==================================================

  display_refresh #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_display_refresh (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sample_count (sample_count),
    .digits       (digits)
  );

  // One decoder per digit, hex[0] is the rightmost
  for (genvar i = 0; i < organ_pkg::NUM_DIGITS; i++)
  begin : g_digit
    seven_seg_decoder u_seven_seg_decoder (
      .digit    (digits[i]),
      .segments (hex[i])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/seven_seg_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module seven_seg_decoder (
  input  wire organ_pkg::hex_digit_t digit,
  output organ_pkg::segments_t       segments
);

  // Segment a in bit 0, g in bit 6, a zero lights the segment
  always_comb
  begin
    case (digit)
      4'h0:    segments = 7'h40;
      4'h1:    segments = 7'h79;
      4'h2:    segments = 7'h24;
      4'h3:    segments = 7'h30;
      4'h4:    segments = 7'h19;
      4'h5:    segments = 7'h12;
      4'h6:    segments = 7'h02;
      4'h7:    segments = 7'h78;
      4'h8:    segments = 7'h00;
      4'h9:    segments = 7'h10;
      // Letters, b and d in lower case
      4'hA:    segments = 7'h08;
      4'hB:    segments = 7'h03;
      4'hC:    segments = 7'h46;
      4'hD:    segments = 7'h21;
      4'hE:    segments = 7'h06;
      default: segments = 7'h0E;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/display_refresh.sv ====
`default_nettype none
`timescale 1ns/100ps

module display_refresh #(
  parameter int unsigned REFRESH_CYCLES = 25000000
) (
  input  wire logic                 CLK_50M,
  input  wire logic                 reset,
  input  wire organ_pkg::sample_count_t sample_count,
  output organ_pkg::display_digits_t digits
);

  localparam int CNT_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
  localparam logic [CNT_W-1:0] REFRESH_LAST = CNT_W'(REFRESH_CYCLES - 1);
  localparam int PAD_W = $bits(organ_pkg::display_digits_t) - $bits(organ_pkg::sample_count_t);

  logic [CNT_W-1:0] refresh_cnt;
  logic             refresh_tick;

  // ==================================================
  // Slow refresh timer
  // ==================================================

  assign refresh_tick = (refresh_cnt == REFRESH_LAST);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      refresh_cnt <= '0;
    else if (refresh_tick)
      refresh_cnt <= '0;
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  // ==================================================
  // Display latch
  // ==================================================

  // Upper digits always read zero
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      digits <= '0;
    else if (refresh_tick)
      digits <= {{PAD_W{1'b0}}, sample_count};
  end

endmodule

`default_nettype wire

// ==== verilog/tone_generator.sv ====
`default_nettype none
`timescale 1ns/100ps

module tone_generator #(
  parameter int unsigned TONE_HALF_CYCLES = 25000
) (
  input  wire logic               CLK_50M,
  input  wire logic               reset,
  input  wire logic               mute,
  output organ_pkg::audio_sample_t audio_sample
);

  localparam int CNT_W = (TONE_HALF_CYCLES > 1) ? $clog2(TONE_HALF_CYCLES) : 1;
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(TONE_HALF_CYCLES - 1);

  logic [CNT_W-1:0] half_cnt;
  logic             square;

  // Square wave, one toggle per half period
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      half_cnt <= '0;
      square   <= 1'b0;
    end
    else if (half_cnt == HALF_LAST)
    begin
      half_cnt <= '0;
      square   <= ~square;
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

  // High gives +127, low gives -128
  always_ff @(posedge CLK_50M)
  begin
    if (mute)
      audio_sample <= '0;
    else
      audio_sample <= {~square, {7{square}}};
  end

endmodule

`default_nettype wire

// ==== verilog/speed_register.sv ====
`default_nettype none
`timescale 1ns/100ps

module speed_register #(
  parameter int DEFAULT_COUNT = 12499,
  parameter int SPEED_STEP    = 100
) (
  input  wire logic               CLK_50M,
  input  wire logic               reset,
  input  wire logic               step_up,
  input  wire logic               step_down,
  input  wire logic               clear_level,
  output organ_pkg::sample_count_t sample_count
);

  localparam organ_pkg::speed_offset_t STEP = organ_pkg::speed_offset_t'(SPEED_STEP);
  localparam organ_pkg::sample_count_t BASE_COUNT = organ_pkg::sample_count_t'(DEFAULT_COUNT);

  organ_pkg::speed_offset_t offset;

  // Clear wins over any step
  // Up and down together cancel out
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      offset <= '0;
    else if (clear_level)
      offset <= '0;
    else if (step_up && !step_down)
      offset <= offset + STEP;
    else if (step_down && !step_up)
      offset <= offset - STEP;
  end

  // Sum wraps modulo 2^16, as the offset does
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_count <= BASE_COUNT;
    else
      sample_count <= BASE_COUNT + organ_pkg::sample_count_t'(offset);
  end

endmodule

`default_nettype wire

// ==== verilog/key_conditioner.sv ====
`default_nettype none
`timescale 1ns/100ps

module key_conditioner #(
  parameter int unsigned REPEAT_CYCLES = 5000000
) (
  input  wire logic                        CLK_50M,
  input  wire logic                        reset,
  input  wire logic [organ_pkg::key_clear:0] keys,
  output logic                             step_up,
  output logic                             step_down,
  output logic                             clear_level
);

  localparam int CNT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;
  localparam logic [CNT_W-1:0] REPEAT_LAST = CNT_W'(REPEAT_CYCLES - 1);

  logic [organ_pkg::key_clear:0] key_meta;
  logic [organ_pkg::key_clear:0] key_sync;
  logic [CNT_W-1:0]              repeat_cnt;
  logic                          repeat_tick;

  // ==================================================
  // Key synchronizer
  // ==================================================

  // Keys are active low, so invert before the first flop
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~keys;
      key_sync <= key_meta;
    end
  end

  // ==================================================
  // Repeat rate and step pulses
  // ==================================================

  assign repeat_tick = (repeat_cnt == REPEAT_LAST);

  // Free running, one tick per REPEAT_CYCLES clocks
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      repeat_cnt <= '0;
    else if (repeat_tick)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // A held key steps once per tick; both keys may pulse together
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end
    else
    begin
      step_up   <= repeat_tick & key_sync[organ_pkg::key_up];
      step_down <= repeat_tick & key_sync[organ_pkg::key_down];
    end
  end

  // Clear is a plain level, no rate limit
  assign clear_level = key_sync[organ_pkg::key_clear];

endmodule

`default_nettype wire

// ==== verilog/organ_pkg.sv ====
`default_nettype none

package organ_pkg;

  // ==================================================
  // Widths that carry a meaning
  // ==================================================

  // Signed offset added to the default sampling count
  typedef logic signed [15:0] speed_offset_t;

  // Sampling-clock count, also what the display shows
  typedef logic [15:0] sample_count_t;

  // Two's complement audio sample
  typedef logic signed [7:0] audio_sample_t;

  // One display nibble
  typedef logic [3:0] hex_digit_t;

  // Segments a..g in bits 0..6, active low
  typedef logic [6:0] segments_t;

  // Number of seven-segment digits on the board
  localparam int NUM_DIGITS = 6;

  // Digit 0 is the least significant nibble
  typedef hex_digit_t [NUM_DIGITS-1:0] display_digits_t;

  // ==================================================
  // Key positions in the key vector
  // ==================================================

  typedef enum logic [1:0] {
    key_up    = 2'd0,
    key_down  = 2'd1,
    key_clear = 2'd2
  } key_index_e;

endpackage

`default_nettype wire
